// ==== laser310_core.f ====
+incdir+testbench
logic/vz_bus_pkg.sv
logic/bus_sequencer.sv
logic/addr_decoder.sv
logic/sync_ram.sv
logic/key_matrix.sv
logic/io_block.sv
logic/laser310_core.sv
testbench/tb_laser310_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the laser310_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing -f laser310_core.f \
	--top-module tb_laser310_core -Mdir "$OBJ_DIR" -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ_DIR/tb_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

grep -qx "Test passed" "$LOG"
if [ $? -ne 0 ]; then
	echo "Pass message not found in $LOG"
	exit 1
fi

exit 0

// ==== testbench/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Board memory map, 0 unmapped, 1 video RAM, 2 I/O window, 3 main RAM
function automatic int ref_region(input addr_t a);
	if (a >= 16'h7000 && a <= 16'h77FF)
		return 1;
	if (a >= 16'h6800 && a <= 16'h6FFF)
		return 2;
	if ((a >= 16'h7800 && a <= 16'h7FFF) || (a >= 16'h8000 && a <= 16'hB7FF))
		return 3;
	return 0;
endfunction

// Both RAMs in one array, the key keeps them apart
data_t mem_model [int];

function automatic int mem_key(input addr_t a);
	if (ref_region(a) == 1)
		return int'(a & 16'h07FF) + 65536; // 2K video RAM
	return int'(a & 16'h3FFF) + 131072;    // 16K main RAM
endfunction

task automatic ref_write(input bus_req_t req);
	int reg_id;
	reg_id = ref_region(req.addr);
	if (req.mreq && req.wr && !req.iorq && (reg_id == 1 || reg_id == 3))
		mem_model[mem_key(req.addr)] = req.wdata;
endtask

// Expected read data, scan is the byte latched at the previous commit
function automatic data_t ref_read(input bus_req_t req, input data_t scan);
	int reg_id;
	reg_id = ref_region(req.addr);
	if (!req.rd || req.iorq || reg_id == 0)
		return 8'hFF;
	if (reg_id == 2)
		return scan;
	if (mem_model.exists(mem_key(req.addr)))
		return mem_model[mem_key(req.addr)];
	return 8'hxx;
endfunction

function automatic mode_t ref_mode(input data_t d);
	mode_t m;
	m.speaker_a = d[0];
	m.speaker_b = d[5];
	m.cass_out  = d[2];
	m.ag        = d[3];
	m.css       = d[4];
	return m;
endfunction

// Low address bits pick rows, a pressed key pulls its column low
function automatic data_t ref_scan(input key_matrix_t m, input logic [7:0] lo, input logic cass);
	data_t s;
	s = 8'hFF;
	for (int c = 0; c < 6; c++)
		for (int r = 0; r < 8; r++)
			if (lo[r] == 1'b0 && m[r*8 + c] == 1'b0)
				s[c] = 1'b0;
	s[6] = ~cass;
	return s;
endfunction

task automatic key_entry(input int k, output key_code_t code, output int pos);
	case (k)
		0: begin code = 8'h15; pos = 4;  end // Q
		1: begin code = 8'h1D; pos = 1;  end // W
		2: begin code = 8'h1C; pos = 12; end // A
		3: begin code = 8'h1A; pos = 20; end // Z
		4: begin code = 8'h16; pos = 28; end // 1
		5: begin code = 8'h29; pos = 36; end // Space
		6: begin code = 8'h45; pos = 44; end // 0
		7: begin code = 8'h4D; pos = 52; end // P
		8: begin code = 8'h33; pos = 56; end // H
		default: begin code = 8'h4B; pos = 57; end // L
	endcase
endtask

task automatic check_data(input string name, input data_t got, input data_t exp);
	if (got !== exp)
	begin
		value_errors++;
		$display("CHECK FAILED %s got %h expected %h", name, got, exp);
	end
endtask

task automatic check_mode(input mode_t got, input mode_t exp);
	if (got !== exp)
	begin
		value_errors++;
		$display("CHECK FAILED mode_o got %h expected %h", got, exp);
	end
endtask

`endif

// ==== testbench/tb_laser310_core.sv ====
`timescale 1ns/1ps

module tb_laser310_core;
	import vz_bus_pkg::*;

	localparam int PLAN_CYCLES = 220;
	localparam int WATCHDOG_NS = PLAN_CYCLES * 14 * 20 + 20000;

	logic        CLK50MHZ = 1'b0;
	logic        RESET_N;
	logic        turbo;
	logic        key_strobe;
	logic        key_pressed;
	logic        cass_in;
	key_code_t   key_code;
	bus_req_t    bus_req;
	data_t       rd_data;
	logic        cpu_clk;
	mode_t       mode;

	int          value_errors = 0;
	int          other_errors = 0;
	key_matrix_t ref_matrix;
	mode_t       exp_mode;
	addr_t       written [$]; // RAM addresses holding known data

	`include "tb_model.svh"

	laser310_core laser310_core_inst
	(
		.CLK50MHZ      (CLK50MHZ),
		.RESET_N       (RESET_N),
		.turbo_i       (turbo),
		.key_strobe_i  (key_strobe),
		.key_pressed_i (key_pressed),
		.cass_in_i     (cass_in),
		.key_code_i    (key_code),
		.bus_i         (bus_req),
		.rd_data_o     (rd_data),
		.cpu_clk_o     (cpu_clk),
		.mode_o        (mode)
	);

	always #10 CLK50MHZ = ~CLK50MHZ; // 50 MHz

	always @(negedge CLK50MHZ)
	begin
		if (!RESET_N && cpu_clk !== 1'b0)
		begin
			other_errors++;
			$display("cpu_clk_o was high while reset was held");
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout after %0d ns, the bus cycles did not complete", WATCHDOG_NS);
		$display("Test failed");
		$finish;
	end

	function automatic bus_req_t make_req(input addr_t a, input data_t d, input logic mreq,
		input logic iorq, input logic rd, input logic wr);
		bus_req_t r;
		r.addr  = a;
		r.wdata = d;
		r.mreq  = mreq;
		r.iorq  = iorq;
		r.rd    = rd;
		r.wr    = wr;
		return r;
	endfunction

	function automatic addr_t rand_addr(input addr_t base, input addr_t mask);
		logic [31:0] r;
		r = $urandom;
		return base | (r[15:0] & mask);
	endfunction

	function automatic data_t rand_byte();
		logic [31:0] r;
		r = $urandom;
		return r[7:0];
	endfunction

	function automatic logic rand_bit();
		logic [31:0] r;
		r = $urandom;
		return r[0];
	endfunction

	// Ends on the falling edge inside a cpu_clk_o pulse
	task automatic wait_pulse();
		@(negedge CLK50MHZ);
		while (!cpu_clk)
			@(negedge CLK50MHZ);
	endtask

	// New request right after the commit edge, read data sampled in the next pulse
	task automatic run_cycle(input bus_req_t req, output data_t rd);
		@(posedge CLK50MHZ);
		#1 bus_req = req;
		wait_pulse();
		rd = rd_data;
	endtask

	task automatic measure_period(output int clocks);
		clocks = 0;
		@(negedge CLK50MHZ);
		clocks++;
		while (!cpu_clk)
		begin
			@(negedge CLK50MHZ);
			clocks++;
		end
	endtask

	task automatic check_period(input int expected);
		int n;
		measure_period(n);
		if (n != expected)
		begin
			other_errors++;
			$display("Bus cycle took %0d clocks where %0d were expected", n, expected);
		end
	endtask

	task automatic set_turbo(input logic enable);
		@(posedge CLK50MHZ);
		#1 turbo = enable;
		wait_pulse();
	endtask

	task automatic press_key(input key_code_t code, input logic pressed, input logic cass);
		@(posedge CLK50MHZ);
		#1;
		key_strobe  = 1'b1;
		key_code    = code;
		key_pressed = pressed;
		cass_in     = cass;
		@(posedge CLK50MHZ);
		#1 key_strobe = 1'b0;
		wait_pulse();
	endtask

	task automatic read_back_all();
		bus_req_t req;
		data_t    got;
		foreach (written[i])
		begin
			req = make_req(written[i], 8'h00, 1'b1, 1'b0, 1'b1, 1'b0);
			run_cycle(req, got);
			check_data("rd_data_o", got, ref_read(req, 8'hFF));
		end
	endtask

	initial
	begin
		bus_req_t  req;
		data_t     got;
		data_t     wd;
		addr_t     a;
		int        n;
		int        pos;
		key_code_t code;
		logic      pressed;
		logic      cass;
		logic [7:0] lo;

		void'($urandom(32'hcd283368));
		RESET_N     = 1'b0;
		turbo       = 1'b0;
		key_strobe  = 1'b0;
		key_pressed = 1'b0;
		key_code    = 8'h00;
		cass_in     = 1'b0;
		bus_req     = make_req(16'h0000, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0);
		ref_matrix  = '1;
		exp_mode    = '0;

		repeat (3) @(posedge CLK50MHZ);
		#1 RESET_N = 1'b1;
		wait_pulse();
		check_mode(mode, exp_mode);

		// Cycle length, the first period after a turbo change may still be the old one
		check_period(14);
		set_turbo(1'b1);
		measure_period(n);
		check_period(4);
		check_period(4);
		set_turbo(1'b0);
		measure_period(n);
		check_period(14);

		for (int i = 0; i < 32; i++)
		begin
			case (i % 3)
				0: a = rand_addr(16'h7000, 16'h07FF);
				1: a = rand_addr(16'h7800, 16'h07FF);
				default: a = 16'h8000 + rand_addr(16'h0000, 16'hFFFF) % 16'h3800;
			endcase
			req = make_req(a, rand_byte(), 1'b1, 1'b0, 1'b0, 1'b1);
			run_cycle(req, got);
			ref_write(req);
			written.push_back(a);
		end
		// 7800 and B000 must land in different main RAM bytes
		wd = rand_byte();
		req = make_req(16'h7800, wd, 1'b1, 1'b0, 1'b0, 1'b1);
		run_cycle(req, got);
		ref_write(req);
		req = make_req(16'hB000, ~wd, 1'b1, 1'b0, 1'b0, 1'b1);
		run_cycle(req, got);
		ref_write(req);
		written.push_back(16'h7800);
		written.push_back(16'hB000);
		read_back_all();

		for (int i = 0; i < 8; i++)
		begin
			req = make_req(rand_addr(16'hC000, 16'h3FFF), 8'h00, 1'b1, 1'b0, 1'b1, 1'b0);
			run_cycle(req, got);
			check_data("rd_data_o", got, ref_read(req, 8'hFF));
			// Port cycles on a RAM address, write then read
			req = make_req(written[i], rand_byte(), 1'b1, 1'b1, 1'b0, 1'b1);
			run_cycle(req, got);
			req = make_req(written[i], 8'h00, 1'b0, 1'b1, 1'b1, 1'b0);
			run_cycle(req, got);
			check_data("rd_data_o", got, ref_read(req, 8'hFF));
		end
		read_back_all();

		for (int i = 0; i < 8; i++)
		begin
			wd = rand_byte();
			req = make_req(16'h6800, wd, 1'b1, 1'b0, 1'b0, 1'b1);
			run_cycle(req, got);
			check_mode(mode, exp_mode); // Latch happens on the following edge
			exp_mode = ref_mode(wd);
			req = make_req(written[i], 8'h00, 1'b1, 1'b0, 1'b1, 1'b0);
			run_cycle(req, got);
			check_mode(mode, exp_mode);
			req = make_req(written[i], rand_byte(), 1'b1, 1'b0, 1'b0, 1'b1);
			run_cycle(req, got);
			ref_write(req);
			check_mode(mode, exp_mode);
			req = make_req(rand_addr(16'h6800, 16'h07FF), 8'h00, 1'b1, 1'b0, 1'b1, 1'b0);
			run_cycle(req, got);
			check_mode(mode, exp_mode);
		end

		for (int i = 0; i < 12; i++)
		begin
			key_entry(int'($urandom % 10), code, pos);
			pressed = rand_bit() | rand_bit(); // Mostly presses
			cass = rand_bit();
			press_key(code, pressed, cass);
			ref_matrix[pos] = ~pressed;
			lo = rand_byte();
			req = make_req({8'h68, lo}, 8'h00, 1'b1, 1'b0, 1'b1, 1'b0);
			run_cycle(req, got);
			run_cycle(req, got);
			check_data("rd_data_o", got, ref_read(req, ref_scan(ref_matrix, lo, cass)));
		end

		$display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== logic/laser310_core.sv ====
`timescale 1ns/1ps

module laser310_core
#(
	parameter int VRAM_AW = vz_bus_pkg::VRAM_AW_DEF,
	parameter int MAIN_AW = vz_bus_pkg::MAIN_AW_DEF
)
(
	input  logic                  CLK50MHZ,
	input  logic                  RESET_N,
	input  logic                  turbo_i,
	input  logic                  key_strobe_i,
	input  logic                  key_pressed_i,
	input  logic                  cass_in_i,
	input  vz_bus_pkg::key_code_t key_code_i,
	input  vz_bus_pkg::bus_req_t  bus_i,
	output vz_bus_pkg::data_t     rd_data_o,
	output logic                  cpu_clk_o,
	output vz_bus_pkg::mode_t     mode_o
);
	import vz_bus_pkg::*;

	logic               commit;
	region_t            region;
	logic [VRAM_AW-1:0] vram_addr;
	logic [MAIN_AW-1:0] main_addr;
	logic               vram_we;
	logic               main_we;
	data_t              vram_rdata;
	data_t              main_rdata;
	key_matrix_t        matrix;

	bus_sequencer seq_inst
	(
		.CLK50MHZ  (CLK50MHZ),
		.RESET_N   (RESET_N),
		.turbo_i   (turbo_i),
		.cpu_clk_o (cpu_clk_o),
		.commit_o  (commit)
	);

	addr_decoder #(.VRAM_AW(VRAM_AW), .MAIN_AW(MAIN_AW)) dec_inst
	(
		.commit_i    (commit),
		.bus_i       (bus_i),
		.region_o    (region),
		.vram_addr_o (vram_addr),
		.main_addr_o (main_addr),
		.vram_we_o   (vram_we),
		.main_we_o   (main_we)
	);

	// 2K screen memory
	sync_ram #(.ADDR_W(VRAM_AW)) vram_inst
	(
		.CLK50MHZ (CLK50MHZ),
		.we_i     (vram_we),
		.addr_i   (vram_addr),
		.wdata_i  (bus_i.wdata),
		.rdata_o  (vram_rdata)
	);

	sync_ram #(.ADDR_W(MAIN_AW)) main_ram_inst
	(
		.CLK50MHZ (CLK50MHZ),
		.we_i     (main_we),
		.addr_i   (main_addr),
		.wdata_i  (bus_i.wdata),
		.rdata_o  (main_rdata)
	);

	key_matrix keys_inst
	(
		.CLK50MHZ      (CLK50MHZ),
		.RESET_N       (RESET_N),
		.key_strobe_i  (key_strobe_i),
		.key_pressed_i (key_pressed_i),
		.key_code_i    (key_code_i),
		.matrix_o      (matrix)
	);

	io_block io_inst
	(
		.CLK50MHZ    (CLK50MHZ),
		.RESET_N     (RESET_N),
		.commit_i    (commit),
		.cass_in_i   (cass_in_i),
		.bus_i       (bus_i),
		.region_i    (region),
		.matrix_i    (matrix),
		.vram_data_i (vram_rdata),
		.main_data_i (main_rdata),
		.rd_data_o   (rd_data_o),
		.mode_o      (mode_o)
	);

endmodule

// ==== logic/io_block.sv ====
`timescale 1ns/1ps

module io_block
(
	input  logic                    CLK50MHZ,
	input  logic                    RESET_N,
	input  logic                    commit_i,
	input  logic                    cass_in_i,
	input  vz_bus_pkg::bus_req_t    bus_i,
	input  vz_bus_pkg::region_t     region_i,
	input  vz_bus_pkg::key_matrix_t matrix_i,
	input  vz_bus_pkg::data_t       vram_data_i,
	input  vz_bus_pkg::data_t       main_data_i,
	output vz_bus_pkg::data_t       rd_data_o,
	output vz_bus_pkg::mode_t       mode_o
);
	import vz_bus_pkg::*;

	data_t scan;
	data_t scan_q;
	mode_t mode_q;
	logic  mode_we;

	// A low address bit selects its row, any pressed key there pulls the column low
	always_comb
	begin
		scan = 8'hFF;
		for (int c = 0; c < 6; c++)
			for (int r = 0; r < 8; r++)
				if (!bus_i.addr[r] && !matrix_i[r*8 + c])
					scan[c] = 1'b0;
		scan[6] = ~cass_in_i; // Tape input, inverted
	end

	assign mode_we = commit_i && bus_i.mreq && bus_i.wr && region_i.io;

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			scan_q <= 8'hFF;
			mode_q <= '0;
		end
		else
		begin
			if (commit_i)
			begin
				scan_q <= scan; // Seen by the CPU one bus cycle later
			end
			if (mode_we)
			begin
				mode_q.speaker_a <= bus_i.wdata[0];
				mode_q.speaker_b <= bus_i.wdata[5];
				mode_q.cass_out  <= bus_i.wdata[2];
				mode_q.ag        <= bus_i.wdata[3];
				mode_q.css       <= bus_i.wdata[4];
			end
		end
	end

	// Nothing selected reads as FF
	always_comb
	begin
		rd_data_o = 8'hFF;
		if (bus_i.rd)
		begin
			if (region_i.vram)
				rd_data_o = vram_data_i;
			else if (region_i.main_ram)
				rd_data_o = main_data_i;
			else if (region_i.io)
				rd_data_o = scan_q;
		end
	end

	assign mode_o = mode_q;

endmodule

// ==== logic/key_matrix.sv ====
`timescale 1ns/1ps

module key_matrix
(
	input  logic                    CLK50MHZ,
	input  logic                    RESET_N,
	input  logic                    key_strobe_i,
	input  logic                    key_pressed_i,
	input  vz_bus_pkg::key_code_t   key_code_i,
	output vz_bus_pkg::key_matrix_t matrix_o
);
	import vz_bus_pkg::*;

	key_matrix_t matrix_q;
	logic [5:0]  key_idx;
	logic        key_hit;

	// Set 2 make codes to row * 8 + column
	always_comb
	begin
		key_hit = 1'b1;
		key_idx = 6'd0;
		case (key_code_i)
			8'h16: key_idx = 6'd28; // 1
			8'h1E: key_idx = 6'd25; // 2
			8'h26: key_idx = 6'd27; // 3
			8'h25: key_idx = 6'd29; // 4
			8'h2E: key_idx = 6'd24; // 5
			8'h36: key_idx = 6'd40; // 6
			8'h3D: key_idx = 6'd45; // 7
			8'h3E: key_idx = 6'd43; // 8
			8'h46: key_idx = 6'd41; // 9
			8'h45: key_idx = 6'd44; // 0
			8'h4E: key_idx = 6'd42; // Minus
			8'h49: key_idx = 6'd33; // Period
			8'h41: key_idx = 6'd35; // Comma
			8'h4C: key_idx = 6'd60; // Semicolon
			8'h52: key_idx = 6'd58; // Quote
			8'h5A: key_idx = 6'd50; // Return
			8'h29: key_idx = 6'd36; // Space
			8'h14: key_idx = 6'd10; // Ctrl
			8'h12: key_idx = 6'd18; // Left shift
			8'h15: key_idx = 6'd4;  // Q
			8'h1D: key_idx = 6'd1;  // W
			8'h24: key_idx = 6'd3;  // E
			8'h2D: key_idx = 6'd5;  // R
			8'h2C: key_idx = 6'd0;  // T
			8'h35: key_idx = 6'd48; // Y
			8'h3C: key_idx = 6'd53; // U
			8'h43: key_idx = 6'd51; // I
			8'h44: key_idx = 6'd49; // O
			8'h4D: key_idx = 6'd52; // P
			8'h1C: key_idx = 6'd12; // A
			8'h1B: key_idx = 6'd9;  // S
			8'h23: key_idx = 6'd11; // D
			8'h2B: key_idx = 6'd13; // F
			8'h34: key_idx = 6'd8;  // G
			8'h33: key_idx = 6'd56; // H
			8'h3B: key_idx = 6'd61; // J
			8'h42: key_idx = 6'd59; // K
			8'h4B: key_idx = 6'd57; // L
			8'h1A: key_idx = 6'd20; // Z
			8'h22: key_idx = 6'd17; // X
			8'h21: key_idx = 6'd19; // C
			8'h2A: key_idx = 6'd21; // V
			8'h32: key_idx = 6'd16; // B
			8'h31: key_idx = 6'd32; // N
			8'h3A: key_idx = 6'd37; // M
			default: key_hit = 1'b0;
		endcase
	end

	// Active low matrix, all keys up after reset
	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			matrix_q <= '1;
		end
		else if (key_strobe_i && key_hit)
		begin
			matrix_q[key_idx] <= ~key_pressed_i;
		end
	end

	assign matrix_o = matrix_q;

endmodule

// ==== logic/sync_ram.sv ====
`timescale 1ns/1ps

module sync_ram
#(
	parameter int ADDR_W = 11
)
(
	input  logic              CLK50MHZ,
	input  logic              we_i,
	input  logic [ADDR_W-1:0] addr_i,
	input  vz_bus_pkg::data_t wdata_i,
	output vz_bus_pkg::data_t rdata_o
);
	import vz_bus_pkg::*;

	data_t mem [0:(2**ADDR_W)-1];

	// Read-before-write on the same address
	always_ff @(posedge CLK50MHZ)
	begin
		if (we_i)
		begin
			mem[addr_i] <= wdata_i;
		end
		rdata_o <= mem[addr_i];
	end

endmodule

// ==== logic/addr_decoder.sv ====
`timescale 1ns/1ps

module addr_decoder
#(
	parameter int VRAM_AW = 11,
	parameter int MAIN_AW = 14
)
(
	input  logic                 commit_i,
	input  vz_bus_pkg::bus_req_t bus_i,
	output vz_bus_pkg::region_t  region_o,
	output logic [VRAM_AW-1:0]   vram_addr_o,
	output logic [MAIN_AW-1:0]   main_addr_o,
	output logic                 vram_we_o,
	output logic                 main_we_o
);
	import vz_bus_pkg::*;

	logic [4:0] a_hi;
	logic       mem_wr;

	assign a_hi = bus_i.addr[15:11]; // 2K granularity

	always_comb
	begin
		region_o          = '0;
		region_o.vram     = (a_hi == 5'b01110);
		region_o.io       = (a_hi == 5'b01101);
		// 7800-7FFF plus 8000-B7FF, B800 and up is not fitted
		region_o.main_ram = (a_hi == 5'b01111) ||
			((bus_i.addr[15:14] == 2'b10) && (a_hi != 5'b10111));
		if (bus_i.iorq)
		begin
			region_o = '0; // Port cycles never hit memory
		end
	end

	// Both RAMs fold onto the low address bits
	assign vram_addr_o = bus_i.addr[VRAM_AW-1:0];
	assign main_addr_o = bus_i.addr[MAIN_AW-1:0];

	assign mem_wr = commit_i && bus_i.mreq && bus_i.wr && !bus_i.iorq;

	assign vram_we_o = mem_wr && region_o.vram;
	assign main_we_o = mem_wr && region_o.main_ram;

endmodule

// ==== logic/bus_sequencer.sv ====
`timescale 1ns/1ps

module bus_sequencer
(
	input  logic CLK50MHZ,
	input  logic RESET_N,
	input  logic turbo_i,
	output logic cpu_clk_o,
	output logic commit_o
);
	import vz_bus_pkg::*;

	logic [3:0] phase;
	logic       cpu_clk_q;
	logic       wrap;

	// Turbo is only looked at in phase 3, so a change waits for the next cycle
	assign wrap = (phase == PHASE_LAST_NORMAL) ||
		((phase == PHASE_LAST_TURBO) && turbo_i);

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			phase     <= 4'd0;
			cpu_clk_q <= 1'b0;
		end
		else
		begin
			if (wrap)
			begin
				phase <= 4'd0;
			end
			else
			begin
				phase <= phase + 4'd1;
			end

			// High for the one clock after phase 0
			cpu_clk_q <= (phase == 4'd0);
		end
	end

	assign cpu_clk_o = cpu_clk_q;

	// Memory side strobe, writes land on the edge that ends it
	assign commit_o = cpu_clk_q;

endmodule

// ==== logic/vz_bus_pkg.sv ====
package vz_bus_pkg;

	typedef logic [15:0] addr_t;    // CPU address
	typedef logic [7:0]  data_t;    // Bus data byte
	typedef logic [7:0]  key_code_t;

	// Row * 8 + column, a 0 means pressed
	typedef logic [63:0] key_matrix_t;

	// Request from the external bus master, levels held for a whole bus cycle
	typedef struct packed
	{
		addr_t addr;
		data_t wdata;
		logic  mreq;
		logic  iorq;
		logic  rd;
		logic  wr;
	} bus_req_t;

	// One-hot memory map selects
	typedef struct packed
	{
		logic vram;     // 7000-77FF
		logic io;       // 6800-6FFF
		logic main_ram; // 7800-7FFF and 8000-B7FF
	} region_t;

	// Latched I/O write bits
	typedef struct packed
	{
		logic speaker_a; // Data bit 0
		logic speaker_b; // Data bit 5
		logic cass_out;  // Data bit 2
		logic ag;        // Data bit 3
		logic css;       // Data bit 4
	} mode_t;

	// Bus cycle length in CLK50MHZ clocks is last phase plus one
	localparam logic [3:0] PHASE_LAST_NORMAL = 4'd13;
	localparam logic [3:0] PHASE_LAST_TURBO  = 4'd3;

	// 2K video RAM, 16K main RAM
	localparam int VRAM_AW_DEF = 11;
	localparam int MAIN_AW_DEF = 14;

endpackage
